/* dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address split, msb to lsb: tag | index | word | byte
`define DCACHE_INDEX_W     4
`define DCACHE_WORD_OFF_W  2
`define DCACHE_OFF_W       (`DCACHE_WORD_OFF_W + 2)
`define DCACHE_TAG_W       (32 - `DCACHE_INDEX_W - `DCACHE_OFF_W)

`define DCACHE_WORDS       (1 << `DCACHE_WORD_OFF_W)
`define DCACHE_LINE_BYTES  (4 * `DCACHE_WORDS)
`define DCACHE_LINE_W      (32 * `DCACHE_WORDS)

// fixed at two, the replacement state is one bit per set
`define DCACHE_WAYS        2

// access size codes
`define DCACHE_SIZE_B      2'd0
`define DCACHE_SIZE_H      2'd1
`define DCACHE_SIZE_W      2'd2

`endif

/* dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        SIZE_B = `DCACHE_SIZE_B,
        SIZE_H = `DCACHE_SIZE_H,
        SIZE_W = `DCACHE_SIZE_W
    } size_e;

    // one request from the pipeline
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        write;   // 1 for store
        size_e       size;
        logic        sign;    // sign-extend loads
    } req_t;

    // a line seen flat for byte merging, or as words for load select
    typedef union packed {
        logic [`DCACHE_LINE_W-1:0]          flat;
        logic [`DCACHE_WORDS-1:0][31:0]     words;
    } line_u;

    typedef struct packed {
        logic                     valid;
        logic [`DCACHE_TAG_W-1:0] tag;
    } tagv_t;

    typedef struct packed {
        logic [31:0] addr;    // line aligned
        line_u       line;
    } mem_xfer_t;

    // write command into the arrays, lands at the next edge
    typedef struct packed {
        logic [`DCACHE_INDEX_W-1:0]    index;
        logic [`DCACHE_WAYS-1:0]       way;      // one-hot, zero for no write
        logic [`DCACHE_LINE_BYTES-1:0] byte_en;
        line_u                         data;
        logic                          tag_we;
        logic [`DCACHE_TAG_W-1:0]      tag;
        logic                          dirty_we;
        logic                          dirty;
    } arr_wr_t;

endpackage

/* dcache_align.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_align (
    input  logic [`DCACHE_OFF_W-1:0]       i_addr_low,
    input  dcache_pkg::size_e              i_size,
    input  logic                           i_signed,
    input  logic [31:0]                    i_wdata,
    input  dcache_pkg::line_u              i_line,
    output dcache_pkg::line_u              o_line_wdata,
    output logic [`DCACHE_LINE_BYTES-1:0]  o_byte_en,
    output logic [31:0]                    o_rdata
);

    logic [1:0]                       byte_off;
    logic [`DCACHE_WORD_OFF_W-1:0]    word_off;
    logic [3:0]                       lane_en;
    logic [31:0]                      lane_data;
    logic [31:0]                      ld_word;

    assign byte_off = i_addr_low[1:0];
    assign word_off = i_addr_low[`DCACHE_OFF_W-1:2];

    always_comb begin
        case (i_size)
            dcache_pkg::SIZE_B: lane_en = 4'b0001;
            dcache_pkg::SIZE_H: lane_en = 4'b0011;
            default:            lane_en = 4'b1111;
        endcase
    end

    // store data copied into every word, byte enables pick the lanes
    assign lane_data          = i_wdata << {byte_off, 3'b000};
    assign o_line_wdata.words = {`DCACHE_WORDS{lane_data}};
    assign o_byte_en = {{(`DCACHE_LINE_BYTES-4){1'b0}}, 4'(lane_en << byte_off)}
                       << {word_off, 2'b00};

    assign ld_word = i_line.words[word_off] >> {byte_off, 3'b000};

    always_comb begin
        case (i_size)
            dcache_pkg::SIZE_B: o_rdata = {{24{i_signed & ld_word[7]}}, ld_word[7:0]};
            dcache_pkg::SIZE_H: o_rdata = {{16{i_signed & ld_word[15]}}, ld_word[15:0]};
            default:            o_rdata = ld_word;
        endcase
    end

endmodule

/* dcache_arrays.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_arrays (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [`DCACHE_INDEX_W-1:0]           i_rd_index,
    input  dcache_pkg::arr_wr_t                  i_wr,
    input  logic                                 i_lru_visit,
    input  logic                                 i_lru_way,
    output dcache_pkg::tagv_t [`DCACHE_WAYS-1:0] o_tagv,
    output dcache_pkg::line_u [`DCACHE_WAYS-1:0] o_data,
    output logic [`DCACHE_WAYS-1:0]              o_dirty,
    output logic                                 o_lru
);

    localparam int SETS       = 1 << `DCACHE_INDEX_W;
    localparam int LINE_BYTES = `DCACHE_LINE_BYTES;

    logic [SETS-1:0] lru_q;

    genvar w;
    generate
        for (w = 0; w < `DCACHE_WAYS; w++) begin : g_way
            logic [LINE_BYTES-1:0][7:0] data_mem [SETS];
            logic [`DCACHE_TAG_W-1:0]   tag_mem [SETS];
            logic [SETS-1:0]            valid_q;
            logic [SETS-1:0]            dirty_q;
            logic                       same_set;
            logic [LINE_BYTES-1:0][7:0] rd_line;
            dcache_pkg::line_u          data_q;
            dcache_pkg::tagv_t          tagv_q;
            logic                       dirty_rd_q;

            assign same_set = i_wr.way[w] && (i_wr.index == i_rd_index);

            // write-first, a store hit is seen by the request right behind it
            always_comb begin
                rd_line = data_mem[i_rd_index];
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (same_set && i_wr.byte_en[b]) begin
                        rd_line[b] = i_wr.data.flat[8*b +: 8];
                    end
                end
            end

            always_ff @(posedge clk) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (i_wr.way[w] && i_wr.byte_en[b]) begin
                        data_mem[i_wr.index][b] <= i_wr.data.flat[8*b +: 8];
                    end
                end
                if (i_wr.way[w] && i_wr.tag_we) begin
                    tag_mem[i_wr.index] <= i_wr.tag;
                end
                data_q       <= rd_line;
                tagv_q.tag   <= (same_set && i_wr.tag_we) ? i_wr.tag : tag_mem[i_rd_index];
                tagv_q.valid <= (same_set && i_wr.tag_we) || valid_q[i_rd_index];
                dirty_rd_q   <= (same_set && i_wr.dirty_we) ? i_wr.dirty : dirty_q[i_rd_index];
            end

            always_ff @(posedge clk) begin
                if (!rstn) begin
                    valid_q <= '0;
                    dirty_q <= '0;
                end else begin
                    if (i_wr.way[w] && i_wr.tag_we) valid_q[i_wr.index] <= 1'b1;
                    if (i_wr.way[w] && i_wr.dirty_we) dirty_q[i_wr.index] <= i_wr.dirty;
                end
            end

            assign o_data[w]  = data_q;
            assign o_tagv[w]  = tagv_q;
            assign o_dirty[w] = dirty_rd_q;
        end
    endgenerate

    // visits use the set of the current write command
    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (i_lru_visit) begin
            lru_q[i_wr.index] <= i_lru_way;
        end
    end

    always_ff @(posedge clk) begin
        o_lru <= (i_lru_visit && (i_wr.index == i_rd_index)) ? i_lru_way : lru_q[i_rd_index];
    end

endmodule

/* dcache_mem_port.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_mem_port (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_refill_start,
    input  logic [31:0]           i_refill_addr,
    output logic                  o_refill_done,
    output dcache_pkg::line_u     o_refill_line,
    input  logic                  i_wb_start,
    input  dcache_pkg::mem_xfer_t i_wb,
    output logic                  o_wb_idle,
    output logic                  o_mem_rd_valid,
    input  logic                  i_mem_rd_ready,
    output logic [31:0]           o_mem_rd_addr,
    input  dcache_pkg::line_u     i_mem_rd_line,
    output logic                  o_mem_wr_valid,
    input  logic                  i_mem_wr_ready,
    output dcache_pkg::mem_xfer_t o_mem_wr
);

    typedef enum logic {
        WB_IDLE,
        WB_WRITE
    } wb_state_e;

    wb_state_e             wb_state_q;
    dcache_pkg::mem_xfer_t wb_buf;
    logic                  rd_hs;

    assign rd_hs = o_mem_rd_valid && i_mem_rd_ready;

    // line read, held until memory takes it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_mem_rd_valid <= 1'b0;
            o_refill_done  <= 1'b0;
        end else begin
            if (i_refill_start) o_mem_rd_valid <= 1'b1;
            else if (rd_hs) o_mem_rd_valid <= 1'b0;
            o_refill_done <= rd_hs;  // one cycle after the handshake
        end
    end

    always_ff @(posedge clk) begin
        if (i_refill_start) o_mem_rd_addr <= i_refill_addr;
        if (rd_hs) o_refill_line <= i_mem_rd_line;  // return buffer
    end

    // write-back engine, runs beside the refill
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_state_q <= WB_IDLE;
        end else begin
            case (wb_state_q)
                WB_IDLE:  if (i_wb_start) wb_state_q <= WB_WRITE;
                WB_WRITE: if (i_mem_wr_ready) wb_state_q <= WB_IDLE;
                default:  wb_state_q <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_wb_start && (wb_state_q == WB_IDLE)) begin
            wb_buf <= i_wb;
        end
    end

    assign o_mem_wr_valid = (wb_state_q == WB_WRITE);
    assign o_mem_wr       = wb_buf;
    assign o_wb_idle      = (wb_state_q == WB_IDLE);

endmodule

/* dcache_lookup.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_lookup (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 i_req_valid,
    input  dcache_pkg::req_t                     i_req,
    output logic                                 o_req_ready,
    output logic                                 o_rsp_valid,
    output logic [31:0]                          o_rsp_rdata,
    output logic [`DCACHE_INDEX_W-1:0]           o_rd_index,
    input  dcache_pkg::tagv_t [`DCACHE_WAYS-1:0] i_tagv,
    input  dcache_pkg::line_u [`DCACHE_WAYS-1:0] i_data,
    input  logic [`DCACHE_WAYS-1:0]              i_dirty,
    input  logic                                 i_lru,
    output dcache_pkg::arr_wr_t                  o_arr_wr,
    output logic                                 o_lru_visit,
    output logic                                 o_lru_way,
    output logic                                 o_refill_start,
    output logic [31:0]                          o_refill_addr,
    input  logic                                 i_refill_done,
    input  dcache_pkg::line_u                    i_refill_line,
    output logic                                 o_wb_start,
    output dcache_pkg::mem_xfer_t                o_wb,
    input  logic                                 i_wb_idle
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_REFILL,
        S_WAIT_WR
    } state_e;

    state_e                          state_q, state_d;
    dcache_pkg::req_t                req_q;
    logic                            vic_q;        // way chosen on the miss
    logic [`DCACHE_TAG_W-1:0]        req_tag;
    logic [`DCACHE_INDEX_W-1:0]      req_index;
    logic [`DCACHE_WAYS-1:0]         hit;
    logic                            hit_way;
    logic                            victim;
    logic                            lookup_hit, lookup_miss, wait_done;
    logic [`DCACHE_WAYS-1:0]         vic_onehot;
    dcache_pkg::line_u               rd_line;
    dcache_pkg::line_u               st_line;
    logic [`DCACHE_LINE_BYTES-1:0]   st_en;
    logic [31:0]                     ld_data;
    dcache_pkg::line_u               merged;

    assign req_tag   = req_q.addr[31 -: `DCACHE_TAG_W];
    assign req_index = req_q.addr[`DCACHE_OFF_W +: `DCACHE_INDEX_W];

    // arrays start reading the next set as soon as it shows up
    assign o_rd_index = i_req.addr[`DCACHE_OFF_W +: `DCACHE_INDEX_W];

    assign hit[0]  = i_tagv[0].valid && (i_tagv[0].tag == req_tag);
    assign hit[1]  = i_tagv[1].valid && (i_tagv[1].tag == req_tag);
    assign hit_way = hit[1];
    assign victim  = ~i_lru;  // lru holds the last visited way

    assign lookup_hit  = (state_q == S_LOOKUP) && (|hit);
    assign lookup_miss = (state_q == S_LOOKUP) && !(|hit);
    assign wait_done   = (state_q == S_WAIT_WR) && i_wb_idle;
    assign vic_onehot  = vic_q ? 2'b10 : 2'b01;

    assign o_req_ready = (state_q == S_IDLE) || lookup_hit || wait_done;
    assign o_rsp_valid = lookup_hit || wait_done;
    assign o_rsp_rdata = req_q.write ? 32'd0 : ld_data;

    // hit data while looking up, refill buffer afterwards
    assign rd_line = (state_q == S_LOOKUP) ? i_data[hit_way] : i_refill_line;

    dcache_align u_align (
        .i_addr_low   (req_q.addr[`DCACHE_OFF_W-1:0]),
        .i_size       (req_q.size),
        .i_signed     (req_q.sign),
        .i_wdata      (req_q.wdata),
        .i_line       (rd_line),
        .o_line_wdata (st_line),
        .o_byte_en    (st_en),
        .o_rdata      (ld_data)
    );

    // pending store bytes over the returned line
    always_comb begin
        merged = i_refill_line;
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            if (req_q.write && st_en[b]) begin
                merged.flat[8*b +: 8] = st_line.flat[8*b +: 8];
            end
        end
    end

    always_comb begin
        o_arr_wr         = '0;
        o_arr_wr.index   = req_index;
        o_arr_wr.tag     = req_tag;
        o_arr_wr.data    = st_line;
        o_arr_wr.byte_en = st_en;
        o_arr_wr.dirty   = req_q.write;
        if (lookup_hit && req_q.write) begin
            o_arr_wr.way      = hit;
            o_arr_wr.dirty_we = 1'b1;
        end else if (state_q == S_REFILL) begin
            o_arr_wr.way      = vic_onehot;
            o_arr_wr.byte_en  = '1;        // whole line
            o_arr_wr.data     = merged;
            o_arr_wr.tag_we   = 1'b1;
            o_arr_wr.dirty_we = 1'b1;
        end
    end

    assign o_lru_visit = lookup_hit || (state_q == S_REFILL);
    assign o_lru_way   = (state_q == S_REFILL) ? vic_q : hit_way;

    assign o_refill_start = lookup_miss;
    assign o_refill_addr  = {req_tag, req_index, {`DCACHE_OFF_W{1'b0}}};

    // victim goes out only when it holds stores
    assign o_wb_start = lookup_miss && i_dirty[victim];
    assign o_wb.addr  = {i_tagv[victim].tag, req_index, {`DCACHE_OFF_W{1'b0}}};
    assign o_wb.line  = i_data[victim];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (i_req_valid) state_d = S_LOOKUP;
            end
            S_LOOKUP: begin
                if (!(|hit)) state_d = S_MISS;
                else if (!i_req_valid) state_d = S_IDLE;
            end
            S_MISS: begin
                if (i_refill_done) state_d = S_REFILL;
            end
            S_REFILL: state_d = S_WAIT_WR;
            S_WAIT_WR: begin
                if (i_wb_idle) state_d = i_req_valid ? S_LOOKUP : S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_valid && o_req_ready) begin
            req_q <= i_req;
        end
        if (lookup_miss) begin
            vic_q <= victim;
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_req_valid,
    input  dcache_pkg::req_t      i_req,
    output logic                  o_req_ready,
    output logic                  o_rsp_valid,
    output logic [31:0]           o_rsp_rdata,
    output logic                  o_mem_rd_valid,
    input  logic                  i_mem_rd_ready,
    output logic [31:0]           o_mem_rd_addr,
    input  dcache_pkg::line_u     i_mem_rd_line,
    output logic                  o_mem_wr_valid,
    input  logic                  i_mem_wr_ready,
    output dcache_pkg::mem_xfer_t o_mem_wr
);

    logic [`DCACHE_INDEX_W-1:0]              rd_index;
    dcache_pkg::tagv_t [`DCACHE_WAYS-1:0]    tagv;
    dcache_pkg::line_u [`DCACHE_WAYS-1:0]    data;
    logic [`DCACHE_WAYS-1:0]                 dirty;
    logic                                    lru;
    dcache_pkg::arr_wr_t                     arr_wr;
    logic                                    lru_visit;
    logic                                    lru_way;
    logic                                    refill_start;
    logic [31:0]                             refill_addr;
    logic                                    refill_done;
    dcache_pkg::line_u                       refill_line;
    logic                                    wb_start;
    dcache_pkg::mem_xfer_t                   wb;
    logic                                    wb_idle;

    dcache_lookup u_lookup (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_req_ready    (o_req_ready),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_rdata    (o_rsp_rdata),
        .o_rd_index     (rd_index),
        .i_tagv         (tagv),
        .i_data         (data),
        .i_dirty        (dirty),
        .i_lru          (lru),
        .o_arr_wr       (arr_wr),
        .o_lru_visit    (lru_visit),
        .o_lru_way      (lru_way),
        .o_refill_start (refill_start),
        .o_refill_addr  (refill_addr),
        .i_refill_done  (refill_done),
        .i_refill_line  (refill_line),
        .o_wb_start     (wb_start),
        .o_wb           (wb),
        .i_wb_idle      (wb_idle)
    );

    dcache_arrays u_arrays (
        .clk         (clk),
        .rstn        (rstn),
        .i_rd_index  (rd_index),
        .i_wr        (arr_wr),
        .i_lru_visit (lru_visit),
        .i_lru_way   (lru_way),
        .o_tagv      (tagv),
        .o_data      (data),
        .o_dirty     (dirty),
        .o_lru       (lru)
    );

    dcache_mem_port u_mem_port (
        .clk            (clk),
        .rstn           (rstn),
        .i_refill_start (refill_start),
        .i_refill_addr  (refill_addr),
        .o_refill_done  (refill_done),
        .o_refill_line  (refill_line),
        .i_wb_start     (wb_start),
        .i_wb           (wb),
        .o_wb_idle      (wb_idle),
        .o_mem_rd_valid (o_mem_rd_valid),
        .i_mem_rd_ready (i_mem_rd_ready),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .i_mem_rd_line  (i_mem_rd_line),
        .o_mem_wr_valid (o_mem_wr_valid),
        .i_mem_wr_ready (i_mem_wr_ready),
        .o_mem_wr       (o_mem_wr)
    );

endmodule

/* tb_dcache_mem.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache_mem #(
    parameter logic [31:0] WIN_BASE = 32'h0001_0000,
    parameter logic [31:0] SEED     = 32'd32
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_rd_valid,
    output logic                  o_rd_ready,
    input  logic [31:0]           i_rd_addr,
    output dcache_pkg::line_u     o_rd_line,
    input  logic                  i_wr_valid,
    output logic                  o_wr_ready,
    input  dcache_pkg::mem_xfer_t i_wr
);

    localparam int          WIN_WORDS = 1024;  // 4 KB window
    localparam logic [31:0] FILL_KEY  = 32'hC3A5_1E96;

    logic [31:0]                    mem_words [WIN_WORDS];  // lines written back by the cache
    logic [31:0]                    shadow [WIN_WORDS];     // stores in program order
    logic [`DCACHE_WORDS-1:0][31:0] rd_words;
    logic [31:0]                    rng;
    logic [1:0]                     rd_delay, rd_wait, wr_delay, wr_wait;
    int                             rd_count, wr_count;
    dcache_pkg::mem_xfer_t          last_wr;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        return shadow[addr[11:2]];
    endfunction

    task automatic record_store(input logic [31:0] addr, input logic [31:0] wdata,
                                input dcache_pkg::size_e size);
        int          nbytes;
        int          lane;
        logic [31:0] w;
        nbytes = (size == dcache_pkg::SIZE_B) ? 1 : (size == dcache_pkg::SIZE_H) ? 2 : 4;
        w      = shadow[addr[11:2]];
        for (int b = 0; b < nbytes; b++) begin
            lane            = int'(addr[1:0]) + b;
            w[8*lane +: 8]  = wdata[8*b +: 8];
        end
        shadow[addr[11:2]] = w;
    endtask

    function automatic logic [31:0] expect_load(input logic [31:0] addr,
                                                input dcache_pkg::size_e size, input logic sign);
        logic [31:0] w;
        w = shadow[addr[11:2]] >> (8 * int'(addr[1:0]));
        case (size)
            dcache_pkg::SIZE_B: return sign ? 32'($signed(w[7:0])) : 32'(w[7:0]);
            dcache_pkg::SIZE_H: return sign ? 32'($signed(w[15:0])) : 32'(w[15:0]);
            default:            return w;
        endcase
    endfunction

    initial begin
        for (int i = 0; i < WIN_WORDS; i++) begin
            mem_words[i] <= (WIN_BASE + 32'(4 * i)) ^ FILL_KEY;
            shadow[i]    = (WIN_BASE + 32'(4 * i)) ^ FILL_KEY;
        end
    end

    for (genvar k = 0; k < `DCACHE_WORDS; k++) begin : g_rd
        assign rd_words[k] = mem_words[{i_rd_addr[11:4], 2'(k)}];
    end
    assign o_rd_line.words = rd_words;

    assign o_rd_ready = i_rd_valid && (rd_wait == rd_delay);
    assign o_wr_ready = i_wr_valid && (wr_wait == wr_delay);

    always @(posedge clk) begin
        if (!rstn) begin
            rng      <= SEED;
            rd_delay <= '0;
            rd_wait  <= '0;
            wr_delay <= '0;
            wr_wait  <= '0;
            rd_count <= 0;
            wr_count <= 0;
        end else begin
            if (o_rd_ready || o_wr_ready) rng <= xorshift32(rng);
            if (o_rd_ready) begin
                rd_count <= rd_count + 1;
                rd_wait  <= '0;
                rd_delay <= rng[1:0];  // wait before the next read
            end else if (i_rd_valid) begin
                rd_wait <= rd_wait + 2'd1;
            end
            if (o_wr_ready) begin
                wr_count <= wr_count + 1;
                wr_wait  <= '0;
                wr_delay <= rng[3:2];
                last_wr  <= i_wr;
                for (int k = 0; k < `DCACHE_WORDS; k++) begin
                    mem_words[{i_wr.addr[11:4], 2'(k)}] <= i_wr.line.words[k];
                end
            end else if (i_wr_valid) begin
                wr_wait <= wr_wait + 2'd1;
            end
        end
    end

endmodule

/* tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 8;
    localparam int          N_RANDOM     = 48;
    localparam int          N_REQS       = 51 + N_RANDOM;  // fixed sequences plus the random mix
    localparam int          WORST_MISS   = 20;             // refill and write-back at max delay
    localparam logic [31:0] WIN_BASE     = 32'h0001_0000;

    logic                  clk = 1'b0;
    logic                  rstn = 1'b0;
    logic                  req_valid = 1'b0;
    dcache_pkg::req_t      req = '0;
    logic                  req_ready, rsp_valid;
    logic [31:0]           rsp_rdata;
    logic                  mem_rd_valid, mem_rd_ready, mem_wr_valid, mem_wr_ready;
    logic [31:0]           mem_rd_addr;
    dcache_pkg::line_u     mem_rd_line;
    dcache_pkg::mem_xfer_t mem_wr;

    logic [31:0] exp_q[$];     // expected responses in program order
    string       name_q[$];
    int          rsp_cycles[$];
    int          cycle = 0;
    logic [31:0] rng;
    string       cur_test = "reset";

    dcache_top dcache_top_inst (
        .clk(clk), .rstn(rstn),
        .i_req_valid(req_valid), .i_req(req), .o_req_ready(req_ready),
        .o_rsp_valid(rsp_valid), .o_rsp_rdata(rsp_rdata),
        .o_mem_rd_valid(mem_rd_valid), .i_mem_rd_ready(mem_rd_ready),
        .o_mem_rd_addr(mem_rd_addr), .i_mem_rd_line(mem_rd_line),
        .o_mem_wr_valid(mem_wr_valid), .i_mem_wr_ready(mem_wr_ready), .o_mem_wr(mem_wr)
    );

    tb_dcache_mem #(.WIN_BASE(WIN_BASE)) mem_inst (
        .clk(clk), .rstn(rstn),
        .i_rd_valid(mem_rd_valid), .o_rd_ready(mem_rd_ready),
        .i_rd_addr(mem_rd_addr), .o_rd_line(mem_rd_line),
        .i_wr_valid(mem_wr_valid), .o_wr_ready(mem_wr_ready), .i_wr(mem_wr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else
            fail_now($sformatf("** Error %s: expected %08h, actual %08h", name, exp, got));
    endtask

    function automatic logic [31:0] next_rand();
        rng = mem_inst.xorshift32(rng);
        return rng;
    endfunction

    // called right after a rising edge and returns at the edge that takes the request
    task automatic send(input logic [31:0] addr, input logic [31:0] wdata, input logic write,
                        input dcache_pkg::size_e size, input logic sign);
        dcache_pkg::req_t r;
        r.addr  = addr;
        r.wdata = wdata;
        r.write = write;
        r.size  = size;
        r.sign  = sign;
        req_valid <= 1'b1;
        req       <= r;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        if (write) begin
            mem_inst.record_store(addr, wdata, size);
            exp_q.push_back(32'd0);  // stores answer with zero
        end else begin
            exp_q.push_back(mem_inst.expect_load(addr, size, sign));
        end
        name_q.push_back(cur_test);
    endtask

    task automatic drain();
        req_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // responses and write-backs sampled mid-cycle
    always @(negedge clk) begin
        if (rstn && rsp_valid) begin
            assert (exp_q.size() != 0) else
                fail_now("a response arrived with no request outstanding");
            check_value(name_q.pop_front(), exp_q.pop_front(), rsp_rdata);
            rsp_cycles.push_back(cycle);
        end
        if (rstn && mem_wr_valid && mem_wr_ready) begin
            for (int k = 0; k < `DCACHE_WORDS; k++) begin
                check_value(cur_test, mem_inst.shadow_word(mem_wr.addr + 32'(4 * k)),
                            mem_wr.line.words[k]);
            end
        end
    end

    initial begin
        #((RESET_CYCLES + N_REQS * WORST_MISS) * CLK_PERIOD);
        fail_now("watchdog expired, the cache stopped answering requests");
    end

    task automatic reads_and_hits();
        int rd_before;
        cur_test  = "read_miss";
        rd_before = mem_inst.rd_count;
        send(WIN_BASE + 32'h48, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);  // cold line
        drain();
        check_value(cur_test, rd_before + 1, mem_inst.rd_count);

        cur_test = "read_hit";
        send(WIN_BASE + 32'h40, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        drain();
        rd_before = mem_inst.rd_count;
        rsp_cycles.delete();
        for (int i = 0; i < 8; i++) begin
            send(WIN_BASE + 32'h40 + 32'(4 * (i % 4)), 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        end
        drain();
        check_value(cur_test, rd_before, mem_inst.rd_count);
        for (int i = 1; i < rsp_cycles.size(); i++) begin
            check_value(cur_test, 1, rsp_cycles[i] - rsp_cycles[i - 1]);
        end
    endtask

    task automatic sub_word_loads();
        logic [31:0] base;
        cur_test = "sub_word";
        send(WIN_BASE + 32'h2C4, 32'h7F80_F105, 1'b1, dcache_pkg::SIZE_W, 1'b0);  // mixed signs
        for (int w = 0; w < 2; w++) begin
            base = (w == 0) ? WIN_BASE + 32'h1A0 : WIN_BASE + 32'h2C4;
            for (int s = 0; s < 2; s++) begin
                for (int off = 0; off < 4; off++) begin
                    send(base + 32'(off), 32'd0, 1'b0, dcache_pkg::SIZE_B, s[0]);
                end
                send(base, 32'd0, 1'b0, dcache_pkg::SIZE_H, s[0]);
                send(base + 32'd2, 32'd0, 1'b0, dcache_pkg::SIZE_H, s[0]);
            end
        end
        drain();
    endtask

    task automatic store_merges();
        logic [31:0]       r;
        logic [31:0]       addr;
        dcache_pkg::size_e size;
        cur_test = "store_merge";
        // one miss per size with junk in the upper data bits
        send(WIN_BASE + 32'h3E1, 32'h5B3C_91A7, 1'b1, dcache_pkg::SIZE_B, 1'b0);
        send(WIN_BASE + 32'h5D2, 32'h0F0F_C35A, 1'b1, dcache_pkg::SIZE_H, 1'b0);
        send(WIN_BASE + 32'h6B8, 32'hDEAD_7E11, 1'b1, dcache_pkg::SIZE_W, 1'b0);
        send(WIN_BASE + 32'h5D1, 32'hAAAA_AA3E, 1'b1, dcache_pkg::SIZE_B, 1'b0);  // hits
        send(WIN_BASE + 32'h6BE, 32'h1111_8D02, 1'b1, dcache_pkg::SIZE_H, 1'b0);
        send(WIN_BASE + 32'h3E4, 32'hC0FF_EE55, 1'b1, dcache_pkg::SIZE_W, 1'b0);
        send(WIN_BASE + 32'h3E0, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        send(WIN_BASE + 32'h3E4, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        send(WIN_BASE + 32'h5D0, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        send(WIN_BASE + 32'h6B8, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        send(WIN_BASE + 32'h6BC, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        send(WIN_BASE + 32'h3E1, 32'd0, 1'b0, dcache_pkg::SIZE_B, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            r = next_rand();
            case (r[13:12])
                2'd0:    size = dcache_pkg::SIZE_B;
                2'd1:    size = dcache_pkg::SIZE_H;
                default: size = dcache_pkg::SIZE_W;
            endcase
            addr = WIN_BASE | {20'd0, r[11:0]};
            if (size == dcache_pkg::SIZE_H) addr[0] = 1'b0;
            if (size == dcache_pkg::SIZE_W) addr[1:0] = 2'b00;
            send(addr, next_rand(), r[14], size, r[15]);
        end
        drain();
    endtask

    task automatic evict_and_reload();
        int wr_before;
        cur_test = "evict_writeback";
        send(WIN_BASE + 32'h354, 32'h1234_5678, 1'b1, dcache_pkg::SIZE_W, 1'b0);  // set 5
        send(WIN_BASE + 32'h758, 32'h9ABC_DEF0, 1'b1, dcache_pkg::SIZE_W, 1'b0);
        drain();
        wr_before = mem_inst.wr_count;
        send(WIN_BASE + 32'hB50, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);  // third tag
        drain();
        check_value(cur_test, wr_before + 1, mem_inst.wr_count);
        check_value(cur_test, WIN_BASE + 32'h350, mem_inst.last_wr.addr);
        send(WIN_BASE + 32'h354, 32'd0, 1'b0, dcache_pkg::SIZE_W, 1'b0);
        drain();
    endtask

    initial begin
        rng = 32'd32;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        reads_and_hits();
        sub_word_loads();
        store_merges();
        evict_and_reload();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
dcache_pkg.sv
dcache_align.sv
dcache_arrays.sv
dcache_mem_port.sv
dcache_lookup.sv
dcache_top.sv
tb_dcache_mem.sv
tb_dcache.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_dcache -f project.f -o tb_dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_dcache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
